// File: vlog.f
board_cfg_pkg.sv
board_io_pkg.sv
joy_conditioner.sv
key_events.sv
input_mapper.sv
game_reset_gen.sv
board_inputs.sv
board_inputs_assert.sv
tb_clock.sv
tb_board_inputs.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board_inputs testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_board_inputs -f vlog.f -Mdir obj_dir -o sim

# The simulator may exit non-zero on failure, the log decides
./obj_dir/sim 2>&1 | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1

// File: tb_board_inputs.sv
// ==========================================================================
// Testbench for board_inputs with BUTTONS = 2, ACTIVE_LOW = 1 and a
// 32-cycle game reset stretch
// Stimulus comes from a 32-bit LFSR, the model runs one step per edge
// and every output is compared on the falling edge
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_board_inputs;
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    localparam int          HOLD            = 32;
    localparam int          RST_CYCLES      = 16;
    localparam int          JOY_CYCLES      = 200;
    localparam int          PAUSE_CYCLES    = 300;
    localparam int          RESET_CYCLES    = 500;
    localparam int          WATCHDOG_CYCLES = RST_CYCLES + 3 * JOY_CYCLES + PAUSE_CYCLES
                                              + RESET_CYCLES + 100;
    localparam logic [31:0] SEED            = 32'h1d84_02f5;

    // Key masks in key_state_t order {pause, reset, service, gfx}
    localparam logic [6:0] KEYS_SERVICE = 7'b001_0000;
    localparam logic [6:0] KEYS_DEBUG   = 7'b101_1111;

    logic                  clk_sys;
    logic                  rst;
    board_joy_arr_t        board_joy;
    key_state_t            keys;
    logic                  en_4way;
    logic                  rotate_en;
    logic                  rst_req;
    logic                  downloading;
    game_joy_arr_t         game_joy;
    player_ctrl_t          player_ctrl;
    logic                  game_pause;
    logic [GFX_LAYERS-1:0] gfx_en;
    logic                  game_rst;

    // Model pipeline and expected outputs
    board_joy_arr_t        m_sync;
    board_joy_arr_t        m_filt;
    key_state_t            m_key;
    key_state_t            m_key_last;
    key_event_t            m_evt;
    logic                  m_soft;
    logic                  m_jp_last;
    int                    quiet;          // Edges since the last reset cause
    game_joy_arr_t         exp_joy;
    player_ctrl_t          exp_ctrl;
    logic                  exp_pause;
    logic [GFX_LAYERS-1:0] exp_gfx;

    logic [31:0] lfsr          = SEED;
    string       test_name     = "reset";
    logic        model_ready   = 1'b0;
    int          releases      = 0;
    logic        last_game_rst = 1'b0;

    tb_clock #(.HALF_PERIOD(5), .RST_CYCLES(RST_CYCLES)) clock_i (
        .clk_sys (clk_sys),
        .rst     (rst)
    );

    board_inputs #(
        .BUTTONS         (2),
        .ACTIVE_LOW      (1'b1),
        .RST_HOLD_CYCLES (HOLD)
    ) dut_i (.*);

    bind board_inputs board_inputs_assert assert_i (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .soft_rst (soft_rst),
        .gfx_en   (gfx_en),
        .game_rst (game_rst)
    );

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_value(input string what, input logic [63:0] exp_v,
                              input logic [63:0] act_v);
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
        $display("Testbench failed");
        $fatal(1, "Output mismatch");
    endtask

    // Model advances last stage first so each stage sees the old value of the one before
    always @(posedge clk_sys) begin : model
        logic [DIR_W-1:0] d;
        logic             jp;
        if (rst) begin
            m_sync      = '0;
            m_filt      = '0;
            m_key       = '0;
            m_key_last  = '0;
            m_evt       = '0;
            m_soft      = 1'b0;
            m_jp_last   = 1'b0;
            quiet       = 0;
            exp_joy     = '1;   // Nothing pressed in active-low form
            exp_ctrl    = '1;
            exp_pause   = 1'b0;
            exp_gfx     = '1;
            model_ready = 1'b1;
        end else begin
            if (rst_req || downloading || m_soft) begin
                quiet = 0;
            end else if (quiet < HOLD) begin
                quiet = quiet + 1;
            end

            for (int p = 0; p < NUM_PLAYERS; p++) begin
                d = m_filt.joy[p].dir;
                if (rotate_en) begin
                    d = {d[2], d[3], d[0], d[1]};   // Up/down and left/right swapped
                end
                exp_joy.joy[p]    = ~{m_filt.joy[p].upper[GAME_JOY_W-DIR_W-1:0], d};
                exp_ctrl.start[p] = ~m_filt.joy[p].upper[START_BASE-DIR_W];
                exp_ctrl.coin[p]  = ~m_filt.joy[p].upper[COIN_BASE-DIR_W];
            end
            exp_ctrl.service = ~m_evt.service;

            jp = m_filt.joy[0].upper[PAUSE_BASE-DIR_W] | m_filt.joy[1].upper[PAUSE_BASE-DIR_W];
            if (downloading) begin
                exp_pause = 1'b0;
            end else if (m_evt.pause || (jp && !m_jp_last)) begin
                exp_pause = ~exp_pause;
            end
            m_jp_last = jp;
            exp_gfx   = exp_gfx ^ m_evt.gfx;
            m_soft    = m_evt.reset;

            // Key edges from the two registered samples
            m_evt.pause   = m_key.pause & ~m_key_last.pause;
            m_evt.reset   = m_key.reset & ~m_key_last.reset;
            m_evt.gfx     = m_key.gfx & ~m_key_last.gfx;
            m_evt.service = m_key.service;
            m_key_last    = m_key;
            m_key         = keys;

            for (int p = 0; p < NUM_PLAYERS; p++) begin
                m_filt.joy[p].upper = m_sync.joy[p].upper;
                if (!en_4way || $countones(m_sync.joy[p].dir) <= 1) begin
                    m_filt.joy[p].dir = m_sync.joy[p].dir;   // Else hold the old one
                end
            end
            m_sync = board_joy;
        end
    end

    always @(negedge clk_sys) begin
        if (model_ready) begin
            assert (game_joy === exp_joy)
                else fail_value("game_joy", 64'(exp_joy), 64'(game_joy));
            assert (player_ctrl === exp_ctrl)
                else fail_value("player_ctrl", 64'(exp_ctrl), 64'(player_ctrl));
            assert (game_pause === exp_pause)
                else fail_value("game_pause", 64'(exp_pause), 64'(game_pause));
            assert (gfx_en === exp_gfx)
                else fail_value("gfx_en", 64'(exp_gfx), 64'(gfx_en));
            assert (game_rst === (quiet < HOLD))
                else fail_value("game_rst", 64'(quiet < HOLD), 64'(game_rst));
            if (last_game_rst && !game_rst) begin
                releases = releases + 1;
            end
            last_game_rst = game_rst;
        end
    end

    // Random inputs for one test with reset causes rare enough for the stretch to end
    task automatic run_phase(input string name, input int cycles, input logic en4,
                             input logic rot, input logic [6:0] key_mask, input logic causes);
        test_name = name;
        repeat (cycles) begin
            @(posedge clk_sys);
            board_joy   <= {rand_bits(32), rand_bits(32)};
            keys        <= 7'(rand_bits(7) & rand_bits(7)) & key_mask;
            en_4way     <= en4;
            rotate_en   <= rot;
            rst_req     <= causes && (rand_bits(7) == 32'd127);
            downloading <= causes && (rand_bits(8) == 32'd255);
            if (causes && rand_bits(7) == 32'd127) begin
                keys.reset <= 1'b1;
            end
        end
    endtask

    initial begin
        board_joy   <= '0;
        keys        <= '0;
        en_4way     <= 1'b0;
        rotate_en   <= 1'b0;
        rst_req     <= 1'b0;
        downloading <= 1'b0;
        @(negedge rst);

        run_phase("joy_map", JOY_CYCLES, 1'b0, 1'b0, KEYS_SERVICE, 1'b0);
        run_phase("joy_rotate", JOY_CYCLES, 1'b0, 1'b1, KEYS_SERVICE, 1'b0);
        run_phase("joy_4way", JOY_CYCLES, 1'b1, 1'b0, KEYS_SERVICE, 1'b0);
        run_phase("pause_gfx", PAUSE_CYCLES, 1'b0, 1'b0, KEYS_DEBUG, 1'b1);
        run_phase("reset_causes", RESET_CYCLES, 1'b0, 1'b0, KEYS_SERVICE, 1'b1);

        @(negedge clk_sys);
        if (releases > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "game_rst was never released");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Testbench failed");
        $fatal(1, "Timeout after %0d cycles, the stimulus did not finish", WATCHDOG_CYCLES);
    end

endmodule

`default_nettype wire

// File: tb_clock.sv
// ==========================================================================
// Testbench clock and reset source
// clk_sys starts low and runs with a 10 ns period
// rst is high from time zero and drops on a rising edge
// after RST_CYCLES edges
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 16
) (
    output logic clk_sys,
    output logic rst
);
    initial begin
        clk_sys = 1'b0;
        forever #(HALF_PERIOD) clk_sys = ~clk_sys;
    end

    initial begin
        rst <= 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        rst <= 1'b0;   // Same edge timing as the other inputs
    end

endmodule

`default_nettype wire

// File: board_inputs_assert.sv
// ==========================================================================
// Concurrent checks bound into board_inputs
// soft_rst is the internal pulse between the mapper and the reset stretcher
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module board_inputs_assert (
    input logic                                 clk_sys,
    input logic                                 rst,
    input logic                                 soft_rst,
    input logic [board_cfg_pkg::GFX_LAYERS-1:0] gfx_en,
    input logic                                 game_rst
);
    // System reset always holds the game in reset
    rst_holds_game: assert property (@(posedge clk_sys) rst |=> game_rst)
        else $error("game_rst was low in the cycle after system reset");

    soft_rst_pulse: assert property (@(posedge clk_sys) soft_rst |=> !soft_rst)
        else $error("soft_rst stayed high for more than one cycle");

    // Every graphics layer comes back on after reset
    gfx_on_after_rst: assert property (@(posedge clk_sys) rst |=> (&gfx_en))
        else $error("gfx_en was not all ones in the cycle after system reset");

endmodule

`default_nettype wire

// File: board_inputs.sv
// ==========================================================================
// Player input and game reset block of the board wrapper
// Single clock domain, synchronous active-high reset
// Joystick and key paths take three cycles to the game outputs
// A key reset press reaches game_rst four cycles later
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module board_inputs #(
    parameter int BUTTONS         = 2,
    parameter bit ACTIVE_LOW      = 1'b1,
    parameter int RST_HOLD_CYCLES = 255
) (
    input  logic                                 clk_sys,
    input  logic                                 rst,
    input  board_io_pkg::board_joy_arr_t         board_joy,
    input  board_io_pkg::key_state_t             keys,
    input  logic                                 en_4way,
    input  logic                                 rotate_en,
    input  logic                                 rst_req,
    input  logic                                 downloading,
    output board_io_pkg::game_joy_arr_t          game_joy,
    output board_io_pkg::player_ctrl_t           player_ctrl,
    output logic                                 game_pause,
    output logic [board_cfg_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic                                 game_rst
);
    import board_io_pkg::*;

    board_joy_arr_t joy_cond;
    key_event_t     key_evt;
    logic           soft_rst;   // One-cycle pulse from the reset key

    joy_conditioner u_joy_cond (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .en_4way   (en_4way),
        .board_joy (board_joy),
        .joy_cond  (joy_cond)
    );

    key_events u_key_events (
        .clk_sys (clk_sys),
        .rst     (rst),
        .keys    (keys),
        .key_evt (key_evt)
    );

    input_mapper #(
        .BUTTONS    (BUTTONS),
        .ACTIVE_LOW (ACTIVE_LOW)
    ) u_mapper (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rotate_en   (rotate_en),
        .downloading (downloading),
        .joy_cond    (joy_cond),
        .key_evt     (key_evt),
        .game_joy    (game_joy),
        .player_ctrl (player_ctrl),
        .game_pause  (game_pause),
        .gfx_en      (gfx_en),
        .soft_rst    (soft_rst)
    );

    game_reset_gen #(
        .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
    ) u_game_rst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .soft_rst    (soft_rst),
        .game_rst    (game_rst)
    );

endmodule

`default_nettype wire

// File: game_reset_gen.sv
// ==========================================================================
// Game reset stretcher
// Causes are system reset, reset request, ROM download and soft reset
// game_rst rises the cycle after a cause and drops RST_HOLD_CYCLES
// cycles after the last cycle a cause was seen
// RST_HOLD_CYCLES must be at least 1
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module game_reset_gen #(
    parameter int RST_HOLD_CYCLES = 255
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic game_rst
);
    import board_io_pkg::*;

    localparam int                CNT_W    = $clog2(RST_HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0]  LAST_CNT = CNT_W'(RST_HOLD_CYCLES - 1);

    rst_state_e       state;
    logic [CNT_W-1:0] hold_cnt;   // Cycles since the last cause
    logic             cause;

    assign cause = rst_req | downloading | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state    <= RST_IDLE;
            hold_cnt <= '0;
        end else if (cause) begin
            state    <= RST_HOLD;   // Restart the stretch
            hold_cnt <= '0;
        end else begin
            case (state)
                RST_IDLE, RST_HOLD: begin
                    if (hold_cnt == LAST_CNT) begin
                        state <= RST_RUN;
                    end else begin
                        state    <= RST_HOLD;
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: state <= RST_RUN;
            endcase
        end
    end

    assign game_rst = (state != RST_RUN);

endmodule

`default_nettype wire

// File: input_mapper.sv
// ==========================================================================
// Maps conditioned joysticks and key events onto the game inputs
// All outputs are registered
// With ACTIVE_LOW set the joysticks, start, coin and service idle at ones
// Rotation swaps right with left and up with down before inversion
// Pause is forced off during ROM download
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module input_mapper #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                                 clk_sys,
    input  logic                                 rst,
    input  logic                                 rotate_en,
    input  logic                                 downloading,
    input  board_io_pkg::board_joy_arr_t         joy_cond,
    input  board_io_pkg::key_event_t             key_evt,
    output board_io_pkg::game_joy_arr_t          game_joy,
    output board_io_pkg::player_ctrl_t           player_ctrl,
    output logic                                 game_pause,
    output logic [board_cfg_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic                                 soft_rst
);
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    localparam int START_BIT = START_BASE + BUTTONS - 2;
    localparam int COIN_BIT  = COIN_BASE + BUTTONS - 2;
    localparam int PAUSE_BIT = PAUSE_BASE + BUTTONS - 2;

    localparam logic [GAME_JOY_W-1:0]  JOY_INV  = {GAME_JOY_W{ACTIVE_LOW}};
    localparam logic [NUM_PLAYERS-1:0] CTRL_INV = {NUM_PLAYERS{ACTIVE_LOW}};

    game_joy_arr_t          joy_next;
    logic [NUM_PLAYERS-1:0] start_raw;
    logic [NUM_PLAYERS-1:0] coin_raw;
    logic                   joy_pause;
    logic                   joy_pause_last;

    function automatic logic [GAME_JOY_W-1:0] map_joy(input board_joy_t raw, input logic rot);
        logic [GAME_JOY_W-1:0] j;
        j = raw[GAME_JOY_W-1:0];
        if (rot) begin
            j[DIR_RIGHT] = raw[DIR_LEFT];
            j[DIR_LEFT]  = raw[DIR_RIGHT];
            j[DIR_DOWN]  = raw[DIR_UP];
            j[DIR_UP]    = raw[DIR_DOWN];
        end
        return j ^ JOY_INV;
    endfunction

    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            joy_next.joy[p] = map_joy(joy_cond.joy[p], rotate_en);
            start_raw[p]    = joy_cond.joy[p][START_BIT];
            coin_raw[p]     = joy_cond.joy[p][COIN_BIT];
        end
    end

    // Either of the first two players can pause
    assign joy_pause = joy_cond.joy[0][PAUSE_BIT] | joy_cond.joy[1][PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy            <= {NUM_PLAYERS{JOY_INV}};
            player_ctrl.start   <= CTRL_INV;
            player_ctrl.coin    <= CTRL_INV;
            player_ctrl.service <= ACTIVE_LOW;
            game_pause          <= 1'b0;
            gfx_en              <= '1;     // All layers on
            soft_rst            <= 1'b0;
            joy_pause_last      <= 1'b0;
        end else begin
            game_joy            <= joy_next;
            player_ctrl.start   <= start_raw ^ CTRL_INV;
            player_ctrl.coin    <= coin_raw ^ CTRL_INV;
            player_ctrl.service <= key_evt.service ^ ACTIVE_LOW;
            joy_pause_last      <= joy_pause;
            soft_rst            <= key_evt.reset;
            gfx_en              <= gfx_en ^ key_evt.gfx;   // Toggle per pulse

            if (downloading) begin
                game_pause <= 1'b0;
            end else if (key_evt.pause || (joy_pause && !joy_pause_last)) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

// File: key_events.sv
// ==========================================================================
// Edge detection for the debug and control keys
// Keys are decoded levels in the clk_sys domain
// Pulses and the service level come out two cycles after the key
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module key_events (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  board_io_pkg::key_state_t keys,
    output board_io_pkg::key_event_t key_evt
);
    import board_io_pkg::*;

    key_state_t key_smp;     // Current sample
    key_state_t key_last;    // Sample one cycle older

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            key_smp  <= '0;
            key_last <= '0;
            key_evt  <= '0;
        end else begin
            key_smp  <= keys;
            key_last <= key_smp;

            // Rising edges only
            key_evt.pause   <= key_smp.pause & ~key_last.pause;
            key_evt.reset   <= key_smp.reset & ~key_last.reset;
            key_evt.gfx     <= key_smp.gfx & ~key_last.gfx;
            key_evt.service <= key_smp.service;   // Held level
        end
    end

endmodule

`default_nettype wire

// File: joy_conditioner.sv
// ==========================================================================
// Board joystick conditioning for all players
// Two register stages for sampling and filtering
// In 4-way mode a diagonal or any multi-direction press keeps the last
// accepted direction, so at most one direction bit reaches the game
// Board inputs must already be in the clk_sys domain or slow enough
// for a single sampling register
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module joy_conditioner (
    input  logic                         clk_sys,
    input  logic                         rst,
    input  logic                         en_4way,
    input  board_io_pkg::board_joy_arr_t board_joy,
    output board_io_pkg::board_joy_arr_t joy_cond
);
    import board_cfg_pkg::*;
    import board_io_pkg::*;

    board_joy_arr_t joy_sync;    // Sampling stage
    board_joy_arr_t joy_filt;    // Filter stage
    logic [NUM_PLAYERS-1:0] dir_ok;

    // First stage copies the board pins
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_sync <= '0;
        end else begin
            joy_sync <= board_joy;
        end
    end

    // Zero or one direction pressed counts as a clean 4-way input
    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            dir_ok[p] = !en_4way || $onehot0(joy_sync.joy[p].dir);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_filt <= '0;
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_filt.joy[p].upper <= joy_sync.joy[p].upper;   // Keeps alignment
                if (dir_ok[p]) begin
                    joy_filt.joy[p].dir <= joy_sync.joy[p].dir;
                end
            end
        end
    end

    assign joy_cond = joy_filt;

endmodule

`default_nettype wire

// File: board_io_pkg.sv
// ==========================================================================
// Bundled joystick, key and player control signals
// All key and joystick bits are active high here
// Inversion for active-low games happens only at the game outputs
// ==========================================================================
`default_nettype none

package board_io_pkg;

    // One board joystick with the directions in the low bits
    typedef struct packed {
        logic [board_cfg_pkg::UPPER_W-1:0] upper;
        logic [board_cfg_pkg::DIR_W-1:0]   dir;
    } board_joy_t;

    // All players with index 0 as player 1
    typedef struct packed {
        board_joy_t [board_cfg_pkg::NUM_PLAYERS-1:0] joy;
    } board_joy_arr_t;

    typedef struct packed {
        logic [board_cfg_pkg::NUM_PLAYERS-1:0][board_cfg_pkg::GAME_JOY_W-1:0] joy;
    } game_joy_arr_t;

    // Decoded key levels from the keyboard side
    typedef struct packed {
        logic                                 pause;
        logic                                 reset;
        logic                                 service;
        logic [board_cfg_pkg::GFX_LAYERS-1:0] gfx;
    } key_state_t;

    // Same layout as key_state_t with one-cycle pulses except service
    typedef struct packed {
        logic                                 pause;
        logic                                 reset;
        logic                                 service;   // Level rather than a pulse
        logic [board_cfg_pkg::GFX_LAYERS-1:0] gfx;
    } key_event_t;

    typedef struct packed {
        logic [board_cfg_pkg::NUM_PLAYERS-1:0] start;
        logic [board_cfg_pkg::NUM_PLAYERS-1:0] coin;
        logic                                  service;
    } player_ctrl_t;

    typedef enum logic [1:0] {
        RST_IDLE,   // System reset seen
        RST_HOLD,   // Counting out the stretch
        RST_RUN     // Game running
    } rst_state_e;

endpackage

`default_nettype wire

// File: board_cfg_pkg.sv
// ==========================================================================
// Widths, bit positions and player count of the board input system
// Direction bits sit at 0 to 3 in the order right, left, down, up
// Start, coin and pause positions assume a two-button game and
// move up by one for every extra button
// ==========================================================================
`default_nettype none

package board_cfg_pkg;

    localparam int NUM_PLAYERS = 4;     // Joystick ports on the board
    localparam int BOARD_JOY_W = 16;    // Bits per board joystick
    localparam int GAME_JOY_W  = 10;    // Bits per game joystick
    localparam int GFX_LAYERS  = 4;

    // Direction field
    localparam int DIR_W     = 4;
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    // Buttons, fire keys and the rest above the directions
    localparam int UPPER_W = BOARD_JOY_W - DIR_W;

    // Positions for BUTTONS == 2
    localparam int START_BASE = 6;
    localparam int COIN_BASE  = 7;
    localparam int PAUSE_BASE = 8;

endpackage

`default_nettype wire
